// ==== tb.f ====
+incdir+.
mvu_cfg_pkg.sv
mvu_ctrl_pkg.sv
acc_ctrl_if.sv
bitplane_agu.sv
ctrl_delay_line.sv
shift_accumulator.sv
mvu_lane_top.sv
mvu_lane_assert.sv
tb_mvu_lane.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_mvu_lane
FILELIST := tb.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) mvu_defines.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_mvu_lane.sv ====
`include "mvu_defines.svh"

module tb_mvu_lane;
    timeunit 1ns;
    timeprecision 1ps;

    import mvu_cfg_pkg::*;
    import mvu_ctrl_pkg::*;

    localparam int   LAT        = `MVU_CTRL_LAT;                    // Address to product cycles
    localparam int   MAX_CYCLES = 6000;                             // About 20 jobs of 8x16 plus drain
    localparam acc_t ACC_MIN    = {1'b1, {(`MVU_BACC-1){1'b0}}};    // Most negative result

    logic    clk;
    logic    rst_n;
    logic    start;
    logic    d_signed;
    prec_t   iprecision;
    addr_t   ibaseaddr;
    stride_t istride;
    length_t ilength;
    logic    max_en;
    logic    max_clr;
    sum_t    vvp_sum;
    logic    rd_en;
    addr_t   rd_addr;
    logic    busy;
    acc_t    result;
    logic    result_valid;
    logic    done;
    logic    irq;
    acc_t    max_result;

    sum_t    mem [0:(1 << `MVU_BADDR)-1];  // Product seen for each data address
    addr_t   exp_addr_q [$];               // Addresses still to be issued
    acc_t    exp_res_q [$];                // Results still to come
    acc_t    max_model;                    // Expected max pooling value
    string   test_name = "reset";
    int      cycles = 0;

    mvu_lane_top mvu_lane_top_inst (
        .clk (clk), .rst_n (rst_n), .start (start), .d_signed (d_signed),
        .iprecision (iprecision), .ibaseaddr (ibaseaddr), .istride (istride),
        .ilength (ilength), .max_en (max_en), .max_clr (max_clr), .vvp_sum (vvp_sum),
        .rd_en (rd_en), .rd_addr (rd_addr), .busy (busy), .result (result),
        .result_valid (result_valid), .done (done), .irq (irq), .max_result (max_result)
    );

    bind mvu_lane_top mvu_lane_assert mvu_lane_assert_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                                      // 8 ns period
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string what, input longint expected, input longint actual);
        assert (expected == actual) else
            stop_run($sformatf("Fail %s %s expected %0d actual %0d",
                               test_name, what, expected, actual));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                                                         // Drive just after the edge
    endtask

    // Every read of the last job must be out once busy drops
    task automatic wait_idle();
        while (busy) next_cycle();
        assert (exp_addr_q.size() == 0) else stop_run("Lane went idle before issuing all reads");
    endtask

    task automatic wait_results();
        while (exp_res_q.size() != 0) next_cycle();
    endtask

    task automatic launch_job(input logic sgn, input int prec, input int len,
                              input int base, input int stride);
        acc_t  expect_acc;
        addr_t a;
        expect_acc = '0;
        wait_idle();
        for (int p = 0; p <= prec; p++) begin
            for (int e = 0; e <= len; e++) begin
                a = addr_t'(base + p * stride + e);
                exp_addr_q.push_back(a);
                if (sgn && p == 0) begin
                    expect_acc = expect_acc - (acc_t'(mem[a]) <<< (prec - p));  // MSB weight -2^P
                end else begin
                    expect_acc = expect_acc + (acc_t'(mem[a]) <<< (prec - p));
                end
            end
        end
        exp_res_q.push_back(expect_acc);
        d_signed   = sgn;
        iprecision = prec_t'(prec);
        ilength    = length_t'(len);
        ibaseaddr  = addr_t'(base);
        istride    = stride_t'(stride);
        start      = 1'b1;
        next_cycle();
        start      = 1'b0;
    endtask

    task automatic launch_random(input logic sgn);
        launch_job(sgn, $urandom_range(7, 0), $urandom_range(15, 0),
                   $urandom_range(30000, 0), $urandom_range(64, 1));
    endtask

    // Start an unrelated job while busy and leave expected queues alone
    task automatic pulse_start_busy();
        assert (busy) else stop_run("Lane was idle where a start during busy was intended");
        ibaseaddr  = addr_t'(15'h7000);
        iprecision = '0;
        ilength    = '0;
        start      = 1'b1;
        next_cycle();
        start      = 1'b0;
    endtask

    // Memory read plus VVP pipeline of LAT cycles from address to sum
    initial begin : vvp_model
        sum_t  pipe_q [$];
        logic  en_now;
        addr_t addr_now;
        vvp_sum = '0;
        repeat (LAT - 1) pipe_q.push_back('0);
        forever begin
            @(posedge clk);
            en_now   = rd_en;
            addr_now = rd_addr;
            #1;
            pipe_q.push_back(en_now ? mem[addr_now] : sum_t'(0));
            vvp_sum = pipe_q.pop_front();
        end
    end

    always @(posedge clk) begin
        acc_t exp_now;
        if (!rst_n) begin
            max_model = ACC_MIN;
        end else begin
            check_value("max_result", longint'(max_model), longint'(max_result));
            if (rd_en) begin
                assert (exp_addr_q.size() > 0) else stop_run("Read issued beyond the job length");
                check_value("rd_addr", longint'(exp_addr_q.pop_front()), longint'(rd_addr));
            end
            if (result_valid) begin
                assert (exp_res_q.size() > 0) else stop_run("Result strobe with no job outstanding");
                exp_now = exp_res_q.pop_front();
                check_value("result", longint'(exp_now), longint'(result));
            end
            if (max_clr) begin
                max_model = ACC_MIN;
            end else if (max_en && result_valid && exp_now > max_model) begin
                max_model = exp_now;
            end
        end
    end

    always @(posedge clk) begin
        if (mvu_lane_top_inst.mvu_lane_assert_inst.fail_cnt != 0) begin
            stop_run("A protocol assertion on the lane outputs failed");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run($sformatf("Timeout after %0d cycles with jobs unfinished", MAX_CYCLES));
        end
    end

    initial begin
        addr_t fill_addr;
        void'($urandom(32'h4a39));
        fill_addr = '0;
        repeat (1 << `MVU_BADDR) begin
            mem[fill_addr] = sum_t'($urandom);
            fill_addr      = fill_addr + 1'b1;
        end
        rst_n      = 1'b0;
        start      = 1'b0;
        d_signed   = 1'b0;
        iprecision = '0;
        ibaseaddr  = '0;
        istride    = '0;
        ilength    = '0;
        max_en     = 1'b0;
        max_clr    = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        next_cycle();

        test_name = "unsigned";
        launch_job(1'b0, 0, 7, 'h40, 16);                            // Single plane
        wait_results();
        launch_job(1'b0, 3, 4, 'h200, 9);
        launch_job(1'b0, 2, 0, 'h300, 1);                            // One element per plane
        launch_job(1'b0, 7, 15, 'h1000, 32);
        wait_results();

        test_name = "signed";
        launch_job(1'b1, 3, 7, 'h2000, 20);
        launch_job(1'b1, 7, 15, 'h3000, 17);                         // Starts while previous drains
        launch_job(1'b1, 0, 5, 'h3800, 3);                           // Sole plane is the MSB
        wait_results();

        test_name = "busy_start";
        launch_job(1'b1, 5, 10, 'h4000, 11);
        launch_job(1'b0, 7, 15, 'h4800, 16);                         // done set again during busy
        repeat (20) next_cycle();
        pulse_start_busy();
        wait_results();

        test_name = "random";
        repeat (6) launch_random(1'($urandom_range(1, 0)));
        wait_results();

        test_name = "max_pool";
        max_en  = 1'b1;
        repeat (2) launch_random(1'b0);                              // Max to be forgotten
        wait_results();
        max_clr = 1'b1;
        next_cycle();
        max_clr = 1'b0;
        repeat (4) launch_random(1'b1);
        wait_results();
        max_en  = 1'b0;                                              // Held value from here on
        repeat (2) launch_random(1'b0);
        wait_results();
        wait_idle();
        repeat (LAT + 2) next_cycle();

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== mvu_lane_assert.sv ====
module mvu_lane_assert (
    input logic clk,           // Lane clock
    input logic rst_n,         // Sync reset
    input logic start,         // Job start
    input logic busy,          // Issuing addresses
    input logic rd_en,         // Read strobe
    input logic result_valid,  // Result strobe
    input logic irq,           // Interrupt
    input logic done           // Job finished
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;  // Failed assertions so far

    // Outputs idle right after a reset edge
    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !rd_en && !busy && !done && !irq && !result_valid)
        else begin
            $error("Outputs not idle after reset");
            fail_cnt++;
        end

    a_rd_busy: assert property (@(posedge clk) disable iff (!rst_n) rd_en == busy)
        else begin
            $error("rd_en and busy differ");
            fail_cnt++;
        end

    a_irq_pulse: assert property (@(posedge clk) disable iff (!rst_n) irq == result_valid)
        else begin
            $error("irq not aligned with result_valid");
            fail_cnt++;
        end

    // Completion is a single cycle strobe
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else begin
            $error("result_valid longer than one cycle");
            fail_cnt++;
        end

    a_done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> result_valid)
        else begin
            $error("done rose without a result");
            fail_cnt++;
        end

    a_done_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> done)
        else begin
            $error("done low while result_valid high");
            fail_cnt++;
        end

    // Only an accepted start clears done
    a_done_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(done) |-> $past(start && !busy))
        else begin
            $error("done fell without an accepted start");
            fail_cnt++;
        end

    a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start && busy && done) |=> done)
        else begin
            $error("start during busy cleared done");
            fail_cnt++;
        end

endmodule

// ==== mvu_lane_top.sv ====
`include "mvu_defines.svh"

module mvu_lane_top (
    input  logic                 clk,           // Clock
    input  logic                 rst_n,         // Sync reset
    input  logic                 start,         // Start a job
    input  logic                 d_signed,      // Input data signed
    input  mvu_cfg_pkg::prec_t   iprecision,    // Bit-planes minus 1
    input  mvu_cfg_pkg::addr_t   ibaseaddr,     // Data base address
    input  mvu_cfg_pkg::stride_t istride,       // Plane stride
    input  mvu_cfg_pkg::length_t ilength,       // Elements minus 1
    input  logic                 max_en,        // Max pooling enable
    input  logic                 max_clr,       // Max pooling clear
    input  mvu_ctrl_pkg::sum_t   vvp_sum,       // Product from memory and VVP
    output logic                 rd_en,         // Data read strobe
    output mvu_cfg_pkg::addr_t   rd_addr,       // Data read address
    output logic                 busy,          // Issuing addresses
    output mvu_ctrl_pkg::acc_t   result,        // Job result
    output logic                 result_valid,  // Result strobe
    output logic                 done,          // Job finished
    output logic                 irq,           // Interrupt
    output mvu_ctrl_pkg::acc_t   max_result     // Max pooled result
);

    acc_ctrl_if agu_ctrl ();                    // AGU to delay line
    acc_ctrl_if acc_ctrl ();                    // Delay line to accumulator

    bitplane_agu bitplane_agu_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .d_signed   (d_signed),
        .iprecision (iprecision),
        .ibaseaddr  (ibaseaddr),
        .istride    (istride),
        .ilength    (ilength),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .busy       (busy),
        .ctrl       (agu_ctrl)
    );

    ctrl_delay_line #(
        .DEPTH      (`MVU_CTRL_LAT)             // Memory read plus VVP stages
    ) ctrl_delay_line_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (agu_ctrl),
        .dout       (acc_ctrl)
    );

    shift_accumulator shift_accumulator_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (acc_ctrl),
        .vvp_sum      (vvp_sum),
        .start        (start & ~busy),          // Only an accepted start clears done
        .max_en       (max_en),
        .max_clr      (max_clr),
        .result       (result),
        .result_valid (result_valid),
        .done         (done),
        .irq          (irq),
        .max_result   (max_result)
    );

endmodule

// ==== shift_accumulator.sv ====
`include "mvu_defines.svh"

module shift_accumulator (
    input  logic                clk,           // Clock
    input  logic                rst_n,         // Sync reset
    acc_ctrl_if.consumer        ctrl,          // Delayed flags
    input  mvu_ctrl_pkg::sum_t  vvp_sum,       // Product aligned with ctrl
    input  logic                start,         // Accepted job start
    input  logic                max_en,        // Max pooling enable
    input  logic                max_clr,       // Max pooling clear
    output mvu_ctrl_pkg::acc_t  result,        // Final job value
    output logic                result_valid,  // Result strobe
    output logic                done,          // Job finished
    output logic                irq,           // Interrupt pulse
    output mvu_ctrl_pkg::acc_t  max_result     // Running maximum
);
    import mvu_ctrl_pkg::*;

    localparam acc_t ACC_MIN = {1'b1, {(`MVU_BACC-1){1'b0}}};  // Most negative value

    acc_t acc;          // Running sum
    acc_t sum_ext;      // Sign-extended product
    acc_t acc_base;     // Value the product is added to
    acc_t acc_next;     // Value after this step
    logic fin;          // Last element being accumulated

    assign sum_ext = {{(`MVU_BACC-`MVU_BSUM){vvp_sum[`MVU_BSUM-1]}}, vvp_sum};

    // Pick the base for this element
    always_comb begin
        if (ctrl.job_first) begin
            acc_base = '0;                      // Fresh job
        end else if (ctrl.plane_first) begin
            acc_base = acc << 1;                // Weight earlier planes by two
        end else begin
            acc_base = acc;
        end
    end

    assign acc_next = ctrl.neg ? (acc_base - sum_ext) : (acc_base + sum_ext);
    assign fin      = ctrl.step && ctrl.job_last;

    // Accumulator register
    always_ff @(posedge clk) begin
        if (ctrl.step) begin
            acc <= acc_next;
        end
    end

    // Capture final value of the job
    always_ff @(posedge clk) begin
        if (fin) begin
            result <= acc_next;
        end
    end

    // Completion flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            result_valid <= fin;                // One-cycle pulse
            if (fin) begin
                done <= 1'b1;                   // Completion wins over a new start
            end else if (start) begin
                done <= 1'b0;                   // Held until next job starts
            end
        end
    end

    assign irq = result_valid;                  // Interrupt shares the completion pulse

    // Max pooling over results since the last clear
    always_ff @(posedge clk) begin
        if (!rst_n || max_clr) begin
            max_result <= ACC_MIN;
        end else if (max_en && result_valid && (result > max_result)) begin
            max_result <= result;               // Signed compare
        end
    end

endmodule

// ==== ctrl_delay_line.sv ====
`include "mvu_defines.svh"

module ctrl_delay_line #(
    parameter int DEPTH = `MVU_CTRL_LAT       // Cycles from address to product
) (
    input  logic         clk,                 // Clock
    input  logic         rst_n,               // Sync reset
    acc_ctrl_if.consumer din,                 // Flags at address issue
    acc_ctrl_if.producer dout                 // Flags at product arrival
);
    import mvu_ctrl_pkg::*;

    acc_ctrl_t in_word;                       // Packed input flags
    acc_ctrl_t pipe [DEPTH];                  // One word per stage

    assign in_word = '{step:        din.step,
                       plane_first: din.plane_first,
                       job_first:   din.job_first,
                       job_last:    din.job_last,
                       neg:         din.neg};

    // Free-running shift so items of back-to-back jobs coexist
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;                // No step in flight after reset
            end
        end else begin
            pipe[0] <= in_word;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout.step        = pipe[DEPTH-1].step;
    assign dout.plane_first = pipe[DEPTH-1].plane_first;
    assign dout.job_first   = pipe[DEPTH-1].job_first;
    assign dout.job_last    = pipe[DEPTH-1].job_last;
    assign dout.neg         = pipe[DEPTH-1].neg;

endmodule

// ==== bitplane_agu.sv ====
module bitplane_agu (
    input  logic                 clk,         // Clock
    input  logic                 rst_n,       // Sync reset
    input  logic                 start,       // Job start strobe
    input  logic                 d_signed,    // Input data is signed
    input  mvu_cfg_pkg::prec_t   iprecision,  // Bit-planes minus 1
    input  mvu_cfg_pkg::addr_t   ibaseaddr,   // Address of first element of MSB plane
    input  mvu_cfg_pkg::stride_t istride,     // Plane to plane distance
    input  mvu_cfg_pkg::length_t ilength,     // Elements minus 1
    output logic                 rd_en,       // Read strobe
    output mvu_cfg_pkg::addr_t   rd_addr,     // Read address
    output logic                 busy,        // Job in progress
    acc_ctrl_if.producer         ctrl         // Flags for the accumulator
);
    import mvu_cfg_pkg::*;

    logic    run;         // Issuing addresses
    prec_t   plane_cnt;   // Current bit-plane, 0 is MSB
    length_t elem_cnt;    // Current element in plane
    prec_t   prec_q;      // Latched precision
    length_t len_q;       // Latched length
    stride_t stride_q;    // Latched stride
    logic    signed_q;    // Latched signedness
    addr_t   plane_base;  // Address of element 0 in current plane
    addr_t   next_base;   // Base of the following plane
    logic    plane_end;   // Last element of a plane
    logic    job_end;     // Last element of the last plane

    assign plane_end = (elem_cnt == len_q);
    assign job_end   = plane_end && (plane_cnt == prec_q);
    assign next_base = plane_base + addr_t'(stride_q);  // Same width so no truncation

    // Counters and run flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            plane_cnt <= '0;
            elem_cnt  <= '0;
        end else if (!run) begin
            if (start) begin                   // Start only honoured when idle
                run       <= 1'b1;
                plane_cnt <= '0;
                elem_cnt  <= '0;
            end
        end else if (plane_end) begin
            elem_cnt  <= '0;                   // Wrap to next plane
            plane_cnt <= plane_cnt + 1'b1;
            if (job_end) begin
                run <= 1'b0;                   // Busy drops with the last read
            end
        end else begin
            elem_cnt <= elem_cnt + 1'b1;
        end
    end

    // Job configuration and address registers
    always_ff @(posedge clk) begin
        if (!run && start) begin
            prec_q     <= iprecision;
            len_q      <= ilength;
            stride_q   <= istride;
            signed_q   <= d_signed;
            plane_base <= ibaseaddr;
            rd_addr    <= ibaseaddr;           // First address out one cycle after start
        end else if (run) begin
            if (plane_end) begin
                plane_base <= next_base;       // Jump by one stride per plane
                rd_addr    <= next_base;
            end else begin
                rd_addr <= rd_addr + 1'b1;     // Consecutive elements
            end
        end
    end

    assign rd_en = run;
    assign busy  = run;

    // Flags follow the address of the same cycle
    assign ctrl.step        = run;
    assign ctrl.plane_first = run && (elem_cnt == '0);
    assign ctrl.job_first   = run && (plane_cnt == '0) && (elem_cnt == '0);
    assign ctrl.job_last    = run && job_end;
    assign ctrl.neg         = run && signed_q && (plane_cnt == '0);  // MSB plane carries -2^P

endmodule

// ==== acc_ctrl_if.sv ====
interface acc_ctrl_if;

    logic step;         // Product valid
    logic plane_first;  // Start of bit-plane so shift first
    logic job_first;    // Start of job so clear first
    logic job_last;     // Completes the job
    logic neg;          // Subtract the product

    // Source of the flags
    modport producer (output step, plane_first, job_first, job_last, neg);

    // Sink of the flags
    modport consumer (input step, plane_first, job_first, job_last, neg);

endinterface

// ==== mvu_ctrl_pkg.sv ====
`include "mvu_defines.svh"

package mvu_ctrl_pkg;

    // Product of one data word with the weight row
    typedef logic signed [`MVU_BSUM-1:0] sum_t;

    // Running shift-accumulate value and job result
    typedef logic signed [`MVU_BACC-1:0] acc_t;

    // Accumulator control word carried alongside each read
    typedef struct packed {
        logic step;         // Product valid this cycle
        logic plane_first;  // First element of a bit-plane
        logic job_first;    // First element of the job
        logic job_last;     // Last element of the job
        logic neg;          // MSB plane of signed data
    } acc_ctrl_t;

endpackage

// ==== mvu_cfg_pkg.sv ====
`include "mvu_defines.svh"

package mvu_cfg_pkg;

    // Input precision stored as number of bit-planes minus 1
    typedef logic [`MVU_BPREC-1:0]   prec_t;

    // Data memory word address
    typedef logic [`MVU_BADDR-1:0]   addr_t;

    // Address distance from one bit-plane to the next
    typedef logic [`MVU_BSTRIDE-1:0] stride_t;

    // Vector length stored as element count minus 1
    typedef logic [`MVU_BLENGTH-1:0] length_t;

endpackage

// ==== mvu_defines.svh ====
`ifndef MVU_DEFINES_SVH
`define MVU_DEFINES_SVH

// Configuration field widths
`define MVU_BPREC        6      // Precision field
`define MVU_BADDR        15     // Data memory address
`define MVU_BLENGTH      15     // Element count field
`define MVU_BSTRIDE      15     // Bit-plane stride

// Datapath widths
`define MVU_BSUM         16     // Signed VVP sum per element
`define MVU_BACC         32     // Shift accumulator

// Pipeline depths between address issue and product arrival
`define MVU_VVPSTAGES    3      // VVP pipeline stages
`define MVU_MEMRDLATENCY 2      // Data memory read latency

// Control flags must line up with the product at the accumulator
`define MVU_CTRL_LAT     (`MVU_VVPSTAGES + `MVU_MEMRDLATENCY)

`endif
